// ==== ddr_line_pkg.sv ====
// Widths and encodings shared by the DDR2 line bridge; every RTL file imports this package
package ddr_line_pkg;

    // ----------------------------------------------------------
    // Geometry of the CPU line and the controller beat
    // ----------------------------------------------------------
    localparam int line_w     = 256;
    localparam int beat_w     = 128;
    localparam int addr_w     = 30;
    localparam int app_addr_w = 27;

    // Line index is CPU word address bits 25 down to 3
    localparam int line_idx_w = 23;

    // Beat address rule
    // Beat 0 sits at the line index followed by five zero bits.
    // Beat 1 sits at the line index followed by the bits 10000.
    // The controller address keeps the low app_addr_w bits of that.

    // ----------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------
    // Controller application commands
    typedef enum logic [2:0] {
        cmd_write = 3'd0,
        cmd_read  = 3'd1
    } mig_cmd_e;

    // Control FSM states
    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_fill,
        st_done
    } ctrl_state_e;

endpackage

// ==== line_req_if.sv ====
// Line request channel from the control FSM to the command issuer, one instance in the top level
`timescale 1ns/1ps

interface line_req_if;
    import ddr_line_pkg::*;

    // One-cycle pulse that opens a request
    logic                  start;
    logic                  write;
    logic [line_idx_w-1:0] line_idx;
    // Filled from the CPU data bus at the top level
    logic [line_w-1:0]     wr_line;
    // One-cycle pulse once every beat of the request is accepted
    logic                  done;

    modport ctrl (
        output start,
        output write,
        output line_idx,
        output wr_line,
        input  done
    );

    modport issue (
        input  start,
        input  write,
        input  line_idx,
        input  wr_line,
        output done
    );

endinterface

// ==== line_ctrl.sv ====
// Control FSM of the line bridge; takes CPU requests, picks hit, miss or write, sequences the datapath
`timescale 1ns/1ps

module line_ctrl (
    input  logic                            ui_clk,
    input  logic                            rst,
    input  logic                            ram_en,
    input  logic                            ram_write,
    input  logic [ddr_line_pkg::addr_w-1:0] ram_addr,
    input  logic                            init_calib_complete,
    output logic                            ram_rdy,
    line_req_if.ctrl                        req,
    input  logic                            hit,
    output logic                            tag_load,
    output logic                            fill_start,
    output logic                            capture,
    input  logic                            fill_done
);
    import ddr_line_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        accept;
    logic        go_ddr;

    // ----------------------------------------------------------
    // CPU side
    // ----------------------------------------------------------
    assign ram_rdy = (state == st_idle) && init_calib_complete;
    assign accept  = ram_en && ram_rdy;

    // Writes always go out, reads only on a miss
    assign go_ddr = accept && (ram_write || !hit);

    // Request fields come straight off the CPU bus, which is held while ram_rdy is low
    assign req.start    = go_ddr;
    assign req.write    = ram_write;
    assign req.line_idx = ram_addr[25:3];

    // Tag and buffer are updated in the accept cycle
    assign tag_load   = go_ddr;
    assign capture    = go_ddr && ram_write;
    assign fill_start = go_ddr && !ram_write;

    // ----------------------------------------------------------
    // State sequencing
    // ----------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (go_ddr) begin
                    state_next = st_issue;
                end
            end
            st_issue: begin
                // Read data may already be complete when the commands finish
                if (req.done) begin
                    if (ram_write || fill_done) begin
                        state_next = st_done;
                    end else begin
                        state_next = st_fill;
                    end
                end
            end
            st_fill: begin
                if (fill_done) begin
                    state_next = st_done;
                end
            end
            st_done: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== line_tag.sv ====
// Tag of the buffered line; holds the last accessed line index and flags a hit on a match
`timescale 1ns/1ps

module line_tag (
    input  logic                                ui_clk,
    input  logic                                rst,
    input  logic                                tag_load,
    input  logic [ddr_line_pkg::line_idx_w-1:0] line_idx,
    output logic                                hit
);
    import ddr_line_pkg::*;

    logic [line_idx_w-1:0] tag_idx;
    logic                  tag_valid;

    // Buffer holds nothing usable until the first access
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            tag_valid <= 1'b0;
        end else if (tag_load) begin
            tag_valid <= 1'b1;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (tag_load) begin
            tag_idx <= line_idx;
        end
    end

    assign hit = tag_valid && (tag_idx == line_idx);

endmodule

// ==== line_buffer.sv ====
// Line store of the bridge; gathers the two read beats and keeps a copy of written lines
`timescale 1ns/1ps

module line_buffer (
    input  logic                            ui_clk,
    input  logic                            rst,
    input  logic                            fill_start,
    input  logic                            capture,
    input  logic [ddr_line_pkg::line_w-1:0] wr_line,
    input  logic [ddr_line_pkg::beat_w-1:0] app_rd_data,
    input  logic                            app_rd_data_valid,
    output logic [ddr_line_pkg::line_w-1:0] rd_line,
    output logic                            fill_done
);
    import ddr_line_pkg::*;

    logic [line_w-1:0] line_q;
    // Low half expected while clear
    logic              beat_q;

    // ----------------------------------------------------------
    // Beat tracking
    // ----------------------------------------------------------
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            beat_q    <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= app_rd_data_valid && beat_q;
            if (fill_start) begin
                beat_q <= 1'b0;
            end else if (app_rd_data_valid) begin
                beat_q <= !beat_q;
            end
        end
    end

    // ----------------------------------------------------------
    // Line storage
    // ----------------------------------------------------------
    always_ff @(posedge ui_clk) begin
        if (capture) begin
            line_q <= wr_line;
        end else if (app_rd_data_valid) begin
            if (beat_q) begin
                line_q[line_w-1:beat_w] <= app_rd_data;
            end else begin
                line_q[beat_w-1:0] <= app_rd_data;
            end
        end
    end

    assign rd_line = line_q;

endmodule

// ==== mig_cmd_issue.sv ====
// Command issuer; drives the controller command and write-data channels for both beats of a line
`timescale 1ns/1ps

module mig_cmd_issue (
    input  logic                                ui_clk,
    input  logic                                rst,
    line_req_if.issue                           req,
    input  logic                                app_rdy,
    input  logic                                app_wdf_rdy,
    output logic                                app_en,
    output ddr_line_pkg::mig_cmd_e              app_cmd,
    output logic [ddr_line_pkg::app_addr_w-1:0] app_addr,
    output logic [ddr_line_pkg::beat_w-1:0]     app_wdf_data,
    output logic                                app_wdf_wren,
    output logic                                app_wdf_end
);
    import ddr_line_pkg::*;

    logic                  cmd_pend;
    logic                  cmd_beat;
    logic                  cmd_last;
    logic                  cmd_fin;
    logic                  dat_beat;
    logic                  dat_last;
    logic                  dat_fin;
    logic                  both_fin;
    logic [line_idx_w+4:0] beat_addr;

    // ----------------------------------------------------------
    // Command channel, first beat offered in the start cycle
    // ----------------------------------------------------------
    assign app_en    = req.start || cmd_pend;
    assign app_cmd   = req.write ? cmd_write : cmd_read;
    assign cmd_last  = app_en && app_rdy && cmd_beat;
    assign beat_addr = {req.line_idx, cmd_beat, 4'b0000};
    // Top index bit lies beyond the controller address space
    assign app_addr  = beat_addr[app_addr_w-1:0];

    // Write data trails the command by one cycle, each beat a full burst
    assign app_wdf_data = dat_beat ? req.wr_line[line_w-1:beat_w] : req.wr_line[beat_w-1:0];
    assign app_wdf_end  = app_wdf_wren;
    assign dat_last     = app_wdf_wren && app_wdf_rdy && dat_beat;

    assign both_fin = (cmd_fin || cmd_last) && (dat_fin || dat_last);

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            cmd_pend     <= 1'b0;
            cmd_beat     <= 1'b0;
            cmd_fin      <= 1'b0;
            app_wdf_wren <= 1'b0;
            dat_beat     <= 1'b0;
            dat_fin      <= 1'b0;
            req.done     <= 1'b0;
        end else begin
            if (app_en && app_rdy) begin
                cmd_beat <= !cmd_beat;
                cmd_pend <= !cmd_beat;
            end else if (req.start) begin
                cmd_pend <= 1'b1;
            end
            if (req.start && req.write) begin
                app_wdf_wren <= 1'b1;
            end else if (app_wdf_wren && app_wdf_rdy) begin
                dat_beat     <= !dat_beat;
                app_wdf_wren <= !dat_beat;
            end
            // Reads have no data to send
            if (req.start) begin
                dat_fin <= !req.write;
            end else begin
                dat_fin <= !both_fin && (dat_fin || dat_last);
            end
            cmd_fin  <= !both_fin && (cmd_fin || cmd_last);
            req.done <= both_fin;
        end
    end

endmodule

// ==== ddr_line_top.sv ====
// Top level of the line bridge; CPU line port on one side, controller application port on the other
`timescale 1ns/1ps

module ddr_line_top (
    input  logic                                ui_clk,
    input  logic                                rst,
    input  logic                                ram_en,
    input  logic                                ram_write,
    input  logic [ddr_line_pkg::addr_w-1:0]     ram_addr,
    input  logic [ddr_line_pkg::line_w-1:0]     data_to_ram,
    output logic                                ram_rdy,
    output logic [ddr_line_pkg::line_w-1:0]     rd_line,
    input  logic                                init_calib_complete,
    input  logic                                app_rdy,
    input  logic                                app_wdf_rdy,
    output logic                                app_en,
    output ddr_line_pkg::mig_cmd_e              app_cmd,
    output logic [ddr_line_pkg::app_addr_w-1:0] app_addr,
    output logic [ddr_line_pkg::beat_w-1:0]     app_wdf_data,
    output logic                                app_wdf_wren,
    output logic                                app_wdf_end,
    input  logic [ddr_line_pkg::beat_w-1:0]     app_rd_data,
    input  logic                                app_rd_data_valid
);

    logic hit;
    logic tag_load;
    logic fill_start;
    logic capture;
    logic fill_done;

    line_req_if req_if ();

    // Write line rides along with the request
    assign req_if.wr_line = data_to_ram;

    line_ctrl u_ctrl (
        .ui_clk(ui_clk), .rst(rst), .ram_en(ram_en), .ram_write(ram_write),
        .ram_addr(ram_addr), .init_calib_complete(init_calib_complete),
        .ram_rdy(ram_rdy), .req(req_if.ctrl), .hit(hit), .tag_load(tag_load),
        .fill_start(fill_start), .capture(capture), .fill_done(fill_done)
    );

    line_tag u_tag (
        .ui_clk(ui_clk), .rst(rst), .tag_load(tag_load),
        .line_idx(req_if.line_idx), .hit(hit)
    );

    line_buffer u_buffer (
        .ui_clk(ui_clk), .rst(rst), .fill_start(fill_start), .capture(capture),
        .wr_line(req_if.wr_line), .app_rd_data(app_rd_data),
        .app_rd_data_valid(app_rd_data_valid), .rd_line(rd_line), .fill_done(fill_done)
    );

    mig_cmd_issue u_issue (
        .ui_clk(ui_clk), .rst(rst), .req(req_if.issue), .app_rdy(app_rdy),
        .app_wdf_rdy(app_wdf_rdy), .app_en(app_en), .app_cmd(app_cmd),
        .app_addr(app_addr), .app_wdf_data(app_wdf_data),
        .app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end)
    );

endmodule

// ==== tb_mig_model.sv ====
// Behavioral model of the DDR2 controller application port; instantiated by the line bridge testbench
`timescale 1ns/1ps

module tb_mig_model (
    input  logic                                ui_clk,
    input  logic                                rst,
    input  logic                                app_en,
    input  ddr_line_pkg::mig_cmd_e              app_cmd,
    input  logic [ddr_line_pkg::app_addr_w-1:0] app_addr,
    input  logic [ddr_line_pkg::beat_w-1:0]     app_wdf_data,
    input  logic                                app_wdf_wren,
    input  logic                                app_wdf_end,
    output logic                                app_rdy,
    output logic                                app_wdf_rdy,
    output logic [ddr_line_pkg::beat_w-1:0]     app_rd_data,
    output logic                                app_rd_data_valid,
    output logic                                init_calib_complete,
    output int                                  cmd_count,
    output logic                                proto_error
);
    import ddr_line_pkg::*;

    // One entry per 16-address burst, indexed by app_addr[16:4]
    logic [beat_w-1:0] mem [0:8191];

    integer            seed = 32'h5137_6bed;
    int                cycle = 0;
    int                calib_cnt = 0;
    logic [12:0]       wr_idx_q[$];
    logic [beat_w-1:0] wr_data_q[$];
    logic [12:0]       rd_idx_q[$];
    int                rd_due_q[$];

    // Unwritten beats read back a pattern built from their index
    initial begin
        for (int i = 0; i < 8192; i++) begin
            mem[i] = {8{i[15:0]}};
        end
    end

    always @(posedge ui_clk) begin
        cycle = cycle + 1;
        app_rd_data_valid <= 1'b0;
        if (!rst) begin
            app_rdy             <= 1'b0;
            app_wdf_rdy         <= 1'b0;
            init_calib_complete <= 1'b0;
            cmd_count           <= 0;
            proto_error         <= 1'b0;
            calib_cnt = 0;
        end else begin
            // ----------------------------------------------------------
            // Command and write-data channels
            // ----------------------------------------------------------
            if (app_en && app_rdy) begin
                cmd_count <= cmd_count + 1;
                if (app_addr[26:17] != 0 || app_addr[3:0] != 0) begin
                    proto_error <= 1'b1;
                end
                if (app_cmd == cmd_write) begin
                    wr_idx_q.push_back(app_addr[16:4]);
                end else begin
                    rd_idx_q.push_back(app_addr[16:4]);
                    rd_due_q.push_back(cycle + 5);
                end
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                wr_data_q.push_back(app_wdf_data);
                if (!app_wdf_end) begin
                    proto_error <= 1'b1;
                end
            end
            // Pair write commands with their data in arrival order
            while (wr_idx_q.size() > 0 && wr_data_q.size() > 0) begin
                mem[wr_idx_q.pop_front()] = wr_data_q.pop_front();
            end

            // Fixed read latency, beats return in command order
            if (rd_due_q.size() > 0 && rd_due_q[0] == cycle) begin
                void'(rd_due_q.pop_front());
                app_rd_data       <= mem[rd_idx_q.pop_front()];
                app_rd_data_valid <= 1'b1;
            end

            // Random back-pressure, ready about three cycles in four
            app_rdy     <= ($random(seed) & 3) != 0;
            app_wdf_rdy <= ($random(seed) & 3) != 0;

            if (calib_cnt < 20) begin
                calib_cnt = calib_cnt + 1;
            end else begin
                init_calib_complete <= 1'b1;
            end
        end
    end

endmodule

// ==== tb_ddr_line.sv ====
// Testbench of the DDR2 line bridge; replays ddr_line_input.txt against the controller model
`timescale 1ns/1ps

module tb_ddr_line;
    import ddr_line_pkg::*;

    logic                  ui_clk;
    logic                  rst;
    logic                  ram_en;
    logic                  ram_write;
    logic [addr_w-1:0]     ram_addr;
    logic [line_w-1:0]     data_to_ram;
    logic                  ram_rdy;
    logic [line_w-1:0]     rd_line;
    logic                  init_calib_complete;
    logic                  app_rdy;
    logic                  app_wdf_rdy;
    logic                  app_en;
    mig_cmd_e              app_cmd;
    logic [app_addr_w-1:0] app_addr;
    logic [beat_w-1:0]     app_wdf_data;
    logic                  app_wdf_wren;
    logic                  app_wdf_end;
    logic [beat_w-1:0]     app_rd_data;
    logic                  app_rd_data_valid;
    int                    cmd_count;
    logic                  proto_error;

    // Operations from the data file
    logic [7:0]        op_q[$];
    logic [addr_w-1:0] addr_q[$];
    logic [line_w-1:0] data_q[$];
    int                ncmd_q[$];
    logic              ops_loaded = 1'b0;

    // Expected DDR contents, one entry per beat
    logic [beat_w-1:0] exp_mem [0:8191];
    logic              exp_written [0:8191];

    ddr_line_top uut (.*);

    tb_mig_model tb_model (.*);

    initial begin
        ui_clk = 1'b0;
        forever #2 ui_clk = ~ui_clk;
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic check(input string name, input logic [line_w-1:0] expv,
                         input logic [line_w-1:0] actv);
        if (expv !== actv) begin
            $display("Error: %s expected %0h actual %0h", name, expv, actv);
            $display("Simulation FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Beat n of a line sits at the line index, then n, then four zero bits
    function automatic int beat_index(input logic [addr_w-1:0] addr, input logic beat);
        logic [27:0] full;
        full = {addr[25:3], beat, 4'b0000};
        return full[16:4];
    endfunction

    task automatic load_ops();
        int                fd;
        int                n;
        string             line;
        logic [7:0]        op;
        logic [addr_w-1:0] addr;
        logic [line_w-1:0] data;
        int                ncmd;
        fd = $fopen("ddr_line_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file ddr_line_input.txt");
            $display("Simulation FAILED");
            $fatal(1, "Missing stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() >= 4 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h %d", op, addr, data, ncmd);
                    if (n != 4) begin
                        $display("Malformed line in the stimulus file: %s", line);
                        $display("Simulation FAILED");
                        $fatal(1, "Bad stimulus file");
                    end else begin
                        op_q.push_back(op);
                        addr_q.push_back(addr);
                        data_q.push_back(data);
                        ncmd_q.push_back(ncmd);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic run_op(input int k);
        string name;
        int    cnt0;
        logic  is_write;
        name     = $sformatf("op %0d %c %h", k + 1, op_q[k], addr_q[k]);
        is_write = (op_q[k] == "W");
        check($sformatf("%s ready before request", name), 1, ram_rdy);
        cnt0        = cmd_count;
        ram_en      = 1'b1;
        ram_write   = is_write;
        ram_addr    = addr_q[k];
        data_to_ram = is_write ? data_q[k] : '0;
        // A hit is answered in the accept cycle
        if (!is_write && ncmd_q[k] == 0) begin
            check($sformatf("%s hit data", name), data_q[k], rd_line);
        end
        @(posedge ui_clk);
        #1;
        ram_en = 1'b0;
        check($sformatf("%s ready after accept", name), ncmd_q[k] == 0, ram_rdy);
        while (!ram_rdy) begin
            @(posedge ui_clk);
            #1;
        end
        if (!is_write) begin
            check($sformatf("%s read data", name), data_q[k], rd_line);
        end
        check($sformatf("%s command count", name), ncmd_q[k], cmd_count - cnt0);
        if (is_write) begin
            exp_mem[beat_index(addr_q[k], 1'b0)]     = data_q[k][beat_w-1:0];
            exp_mem[beat_index(addr_q[k], 1'b1)]     = data_q[k][line_w-1:beat_w];
            exp_written[beat_index(addr_q[k], 1'b0)] = 1'b1;
            exp_written[beat_index(addr_q[k], 1'b1)] = 1'b1;
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        rst         = 1'b0;
        ram_en      = 1'b0;
        ram_write   = 1'b0;
        ram_addr    = '0;
        data_to_ram = '0;
        for (int i = 0; i < 8192; i++) begin
            exp_written[i] = 1'b0;
        end
        load_ops();
        ops_loaded = 1'b1;

        repeat (16) begin
            @(posedge ui_clk);
            #1;
            check("ready during reset", 0, ram_rdy);
        end
        rst = 1'b1;
        while (!init_calib_complete) begin
            check("ready before calibration", 0, ram_rdy);
            @(posedge ui_clk);
            #1;
        end
        check("ready after calibration", 1, ram_rdy);

        foreach (op_q[k]) begin
            run_op(k);
        end

        // Model memory against every write in the file
        for (int i = 0; i < 8192; i++) begin
            if (exp_written[i]) begin
                check($sformatf("memory beat %0d", i), exp_mem[i], tb_model.mem[i]);
            end
        end
        check("controller protocol", 0, proto_error);
        $display("Simulation PASSED");
        $finish;
    end

    // Hang guard, 400 cycles per operation plus one slot for reset
    initial begin
        wait (ops_loaded);
        repeat ((op_q.size() + 1) * 400) @(posedge ui_clk);
        $display("Timeout: the bridge did not finish all operations in time");
        $display("Simulation FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== ddr_line_input.txt ====
# op (W write, R read)  word address (hex)  line (hex, write data or expected read)  commands
# commands is the number of controller commands expected: 2 for a write or a miss, 0 for a hit
W 00000100 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 2
W 00000010 1111111111111111222222222222222233333333333333334444444444444444 2
R 00000100 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 2
R 00000010 1111111111111111222222222222222233333333333333334444444444444444 2
R 00000010 1111111111111111222222222222222233333333333333334444444444444444 0
W 00000010 0123456789abcdeffedcba98765432100f1e2d3c4b5a69788796a5b4c3d2e1f0 2
R 00000010 0123456789abcdeffedcba98765432100f1e2d3c4b5a69788796a5b4c3d2e1f0 0
W 00000a08 deadbeefdeadbeefdeadbeefdeadbeefcafef00dcafef00dcafef00dcafef00d 2
W 00007ff8 ffffffffffffffffffffffffffffffff00000000000000000000000000000000 2
R 00000a08 deadbeefdeadbeefdeadbeefdeadbeefcafef00dcafef00dcafef00dcafef00d 2
W 00007ff8 13579bdf2468ace013579bdf2468ace0fedcba9876543210fedcba9876543210 2
R 00007ff8 13579bdf2468ace013579bdf2468ace0fedcba9876543210fedcba9876543210 0
R 00000100 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 2
R 00000014 0123456789abcdeffedcba98765432100f1e2d3c4b5a69788796a5b4c3d2e1f0 2
R 00000017 0123456789abcdeffedcba98765432100f1e2d3c4b5a69788796a5b4c3d2e1f0 0
W 00000100 1111111111111111222222222222222233333333333333334444444444444444 2
R 00000100 1111111111111111222222222222222233333333333333334444444444444444 0

// ==== build.f ====
ddr_line_pkg.sv
line_req_if.sv
line_ctrl.sv
line_tag.sv
line_buffer.sv
mig_cmd_issue.sv
ddr_line_top.sv
tb_mig_model.sv
tb_ddr_line.sv

// ==== Bender.yml ====
package:
  name: ddr_line_bridge

sources:
  - files:
      - ddr_line_pkg.sv
      - line_req_if.sv
      - line_ctrl.sv
      - line_tag.sv
      - line_buffer.sv
      - mig_cmd_issue.sv
      - ddr_line_top.sv
  - target: test
    files:
      - tb_mig_model.sv
      - tb_ddr_line.sv
